// File: verilog.f
source/histPkg.sv
source/histBuilder.sv
source/acqControl.sv
source/axiLiteRegs.sv
source/timeHistTop.sv
verification/clkGen.sv
verification/timeHistChk.sv
verification/timeHistTb.sv

// File: Makefile
TOP = timeHistTb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

// File: verification/timeHistTb.sv
`timescale 1ns/1ps

module timeHistTb;

    import histPkg::*;

    localparam int nb = defNb;
    localparam int nf = defNf;
    localparam int tw = nb + nf;
    localparam int numAcq = defNumAcq;
    localparam int period = 40;
    localparam int numRuns = 4;                     // starts issued below
    localparam logic [tw-1:0] tieFirst = {nb'(40), nf'(11)};
    localparam logic [tw-1:0] tieSecond = {nb'(12), nf'(2)};

    logic          clk;
    logic          res;
    logic          hitValid;
    logic [tw-1:0] hitTime;
    logic          hitReady;
    logic          irq;
    logic [4:0]    awaddr;
    logic          awvalid;
    logic          awready;
    logic [31:0]   wdata;
    logic          wvalid;
    logic          wready;
    logic [1:0]    bresp;
    logic          bvalid;
    logic          bready;
    logic [4:0]    araddr;
    logic          arvalid;
    logic          arready;
    logic [31:0]   rdata;
    logic [1:0]    rresp;
    logic          rvalid;
    logic          rready;

    integer        seed = 28359;
    int            checks = 0;
    int            valueErrors = 0;
    int            protoErrors = 0;
    logic [tw-1:0] accHits[$];                      // hits taken in this acquisition
    string         nameQ[$];
    logic [31:0]   expQ[$];
    logic [31:0]   actQ[$];

    clkGen #(.period(period), .resCycles(5)) i_clk (.clk(clk), .res(res));

    timeHistTop i_dut (.*);

    // expected results from replaying the accepted hits
    function automatic void refHist(output logic [31:0] pos, output logic [31:0] cPeak,
                                    output logic [31:0] fPeak);
        int         coarseHist[2**nb] = '{default: 0};
        int         fineHist[2**nf] = '{default: 0};
        int         cMax;
        int         fMax;
        logic [nb-1:0] cBin;
        logic [nf-1:0] fBin;
        cMax = 0;
        fMax = 0;
        cBin = '0;
        fBin = '0;
        foreach (accHits[i]) begin
            coarseHist[accHits[i][tw-1:nf]]++;
            fineHist[accHits[i][nf-1:0]]++;
            // strictly greater so the earlier bin wins a tie
            if (coarseHist[accHits[i][tw-1:nf]] > cMax) begin
                cMax = coarseHist[accHits[i][tw-1:nf]];
                cBin = accHits[i][tw-1:nf];
            end
            if (fineHist[accHits[i][nf-1:0]] > fMax) begin
                fMax = fineHist[accHits[i][nf-1:0]];
                fBin = accHits[i][nf-1:0];
            end
        end
        pos = 32'({cBin, fBin});
        cPeak = 32'(cMax);
        fPeak = 32'(fMax);
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            valueErrors++;
            $display("FAILED at %0d ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
        end
    endtask

    task automatic pushCheck(input string name, input logic [31:0] exp, input logic [31:0] act);
        nameQ.push_back(name);
        expQ.push_back(exp);
        actQ.push_back(act);
    endtask

    task automatic protoFail(input string what);
        protoErrors++;
        $display("protocol error at %0d ns: %s", $time, what);
    endtask

    // comparing process
    always @(negedge clk) begin
        while (expQ.size() > 0) begin
            compare(nameQ.pop_front(), expQ.pop_front(), actQ.pop_front());
        end
    end

    task automatic axiWrite(input logic [4:0] addr, input logic [31:0] data, input bit dataFirst);
        bit awTaken;
        bit wTaken;
        int n;
        n = 0;
        @(negedge clk);
        awaddr = addr;
        wdata = data;
        wvalid = 1'b1;
        awvalid = !dataFirst;
        while ((awvalid || wvalid) && n < 20) begin
            awTaken = awvalid && awready;           // ready only moves on rising edges
            wTaken = wvalid && wready;
            @(negedge clk);
            if (awTaken) awvalid = 1'b0;
            if (wTaken) wvalid = 1'b0;
            if (wTaken && dataFirst) awvalid = 1'b1;
            n++;
        end
        bready = 1'b1;
        while (!bvalid && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (n >= 20) protoFail("write handshake did not complete");
        pushCheck("bresp", 32'd0, 32'(bresp));
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic readExpect(input logic [4:0] addr, input string name,
                              input logic [31:0] exp, input int holdOff);
        int n;
        n = 0;
        @(negedge clk);
        araddr = addr;
        arvalid = 1'b1;
        while (!arready && n < 20) begin
            @(negedge clk);
            n++;
        end
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (n >= 20) protoFail("read handshake did not complete");
        repeat (holdOff) @(negedge clk);            // response back-pressure
        rready = 1'b1;
        pushCheck(name, exp, rdata);
        pushCheck("rresp", 32'd0, 32'(rresp));
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic offerHit(input logic [tw-1:0] t, output bit taken);
        @(negedge clk);
        hitValid = 1'b1;
        hitTime = t;
        taken = hitReady;                           // stable until the next rising edge
        if (taken) accHits.push_back(t);
    endtask

    task automatic sendHit(input logic [tw-1:0] t);
        bit taken;
        int n;
        taken = 1'b0;
        n = 0;
        while (!taken && n < 50) begin
            offerHit(t, taken);
            n++;
        end
        if (!taken) protoFail("hit was never accepted");
    endtask

    task automatic dropHit();
        @(negedge clk);
        hitValid = 1'b0;
    endtask

    task automatic runRandom(input int count);
        while (accHits.size() < count && protoErrors == 0) begin
            sendHit(tw'($random(seed)));
        end
        dropHit();
    endtask

    // hits while not ready must be ignored
    task automatic strayHit(input int cycles);
        bit taken;
        logic [tw-1:0] t;
        t = tw'($random(seed));
        repeat (cycles) begin
            offerHit(t, taken);
            pushCheck("hitReady", 32'd0, 32'(taken));
        end
        dropHit();
    endtask

    task automatic startAcq(input bit dataFirst);
        accHits.delete();
        axiWrite(regCtrl, 32'd1, dataFirst);
    endtask

    task automatic waitIrq();
        int n;
        n = 0;
        while (!irq && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!irq) protoFail("irq did not rise after the last hit");
    endtask

    task automatic checkResults(input int holdOff);
        logic [31:0] pos;
        logic [31:0] cPeak;
        logic [31:0] fPeak;
        refHist(pos, cPeak, fPeak);
        readExpect(regPeak, "regPeak", pos, holdOff);
        readExpect(regCoarseCount, "regCoarseCount", cPeak, holdOff);
        readExpect(regFineCount, "regFineCount", fPeak, holdOff);
        readExpect(regStatus, "regStatus", 32'd2, holdOff);
        pushCheck("irq", 32'd1, 32'(irq));
    endtask

    initial begin
        hitValid = 1'b0;
        hitTime = '0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        wait (res === 1'b1);
        pushCheck("irq", 32'd0, 32'(irq));
        strayHit(4);                                // idle so nothing is counted
        readExpect(regStatus, "regStatus", 32'd0, 0);
        // random run with a status read midway
        startAcq(1'b0);
        runRandom(numAcq / 2);
        readExpect(regStatus, "regStatus", 32'd1, 0);
        pushCheck("irq", 32'd0, 32'(irq));
        runRandom(numAcq);
        waitIrq();
        strayHit(4);
        checkResults(0);
        // data before address and a restart while busy
        startAcq(1'b1);
        pushCheck("irq", 32'd0, 32'(irq));          // dropped by the new start
        runRandom(10);
        startAcq(1'b0);
        runRandom(numAcq);
        waitIrq();
        checkResults(5);
        // both bins tie at numAcq/2 and the first one keeps the peak
        startAcq(1'b0);
        for (int i = 0; i < numAcq; i++) begin
            sendHit((i % 2 == 0) ? tieFirst : tieSecond);
        end
        dropHit();
        waitIrq();
        checkResults(3);
        readExpect(regPeak, "regPeak", 32'(tieFirst), 0);
        readExpect(regCoarseCount, "regCoarseCount", 32'(numAcq / 2), 0);
        while (expQ.size() > 0) @(negedge clk);
        @(negedge clk);
        $display("checks %0d, value errors %0d, protocol errors %0d",
                 checks, valueErrors, protoErrors);
        if (valueErrors == 0 && protoErrors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(period * (numRuns * (numAcq + 50) + 500));
        $display("timeout: the run did not finish in time");
        $display("test failed");
        $finish;
    end

endmodule

// File: verification/timeHistChk.sv
`timescale 1ns/1ps

module timeHistChk #(
    parameter int countWidth = histPkg::defCountWidth
) (
    input logic                  clk,
    input logic                  res,
    input logic                  hitReady,
    input logic                  busy,
    input logic                  done,
    input logic                  start,
    input logic [countWidth-1:0] coarseCount,
    input logic [countWidth-1:0] fineCount,
    input logic                  bvalid,
    input logic                  bready,
    input logic                  rvalid,
    input logic                  rready,
    input logic [31:0]           rdata
);

    // histogram is final once done and stays so until the next start
    readyLowInDone: assert property (@(posedge clk) disable iff (!res)
        done && !start |=> done && !hitReady)
        else $error("done dropped without a start or hitReady high while done");

    bHeld: assert property (@(posedge clk) disable iff (!res) bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    rHeld: assert property (@(posedge clk) disable iff (!res)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("read data not held until rready");

    // builders wiped on the start edge
    clearWithStart: assert property (@(posedge clk) disable iff (!res)
        start |=> busy && (coarseCount == '0) && (fineCount == '0))
        else $error("peaks not cleared on the start edge");

endmodule

// all watched nets meet in the top level
bind timeHistTop timeHistChk i_chk (.*);

// File: verification/clkGen.sv
`timescale 1ns/1ps

module clkGen #(
    parameter int period = 40,
    parameter int resCycles = 5
) (
    output logic clk,
    output logic res
);

    initial begin
        clk = 1'b0;
        res = 1'b0;                       // reset active from time zero
        repeat (resCycles) @(posedge clk);
        @(negedge clk);
        res = 1'b1;
    end

    always #(period / 2) clk = ~clk;

endmodule

// File: source/timeHistTop.sv
`timescale 1ns/1ps

module timeHistTop #(
    parameter int nb = histPkg::defNb,
    parameter int nf = histPkg::defNf,
    parameter int countWidth = histPkg::defCountWidth,
    parameter int numAcq = histPkg::defNumAcq
) (
    input  logic             clk,
    input  logic             res,
    input  logic             hitValid,
    input  logic [nb+nf-1:0] hitTime,
    output logic             hitReady,
    output logic             irq,
    input  logic [4:0]       awaddr,
    input  logic             awvalid,
    output logic             awready,
    input  logic [31:0]      wdata,
    input  logic             wvalid,
    output logic             wready,
    output logic [1:0]       bresp,
    output logic             bvalid,
    input  logic             bready,
    input  logic [4:0]       araddr,
    input  logic             arvalid,
    output logic             arready,
    output logic [31:0]      rdata,
    output logic [1:0]       rresp,
    output logic             rvalid,
    input  logic             rready
);

    logic                  hitAccept;
    logic                  clear;
    logic                  start;
    logic                  busy;
    logic                  done;
    logic [nb-1:0]         coarseBin;
    logic [nf-1:0]         fineBin;
    logic [countWidth-1:0] coarseCount;
    logic [countWidth-1:0] fineCount;
    logic [nb+nf-1:0]      peakPos;
    logic [countWidth-1:0] coarsePeak;
    logic [countWidth-1:0] finePeak;

    // coarse period index from the upper timestamp bits
    histBuilder #(
        .addrWidth (nb),
        .countWidth(countWidth)
    ) i_coarse (
        .clk      (clk),
        .res      (res),
        .clear    (clear),
        .hitAccept(hitAccept),
        .binAddr  (hitTime[nb+nf-1:nf]),
        .peakBin  (coarseBin),
        .peakCount(coarseCount)
    );

    // phase within the coarse period
    histBuilder #(
        .addrWidth (nf),
        .countWidth(countWidth)
    ) i_fine (
        .clk      (clk),
        .res      (res),
        .clear    (clear),
        .hitAccept(hitAccept),
        .binAddr  (hitTime[nf-1:0]),
        .peakBin  (fineBin),
        .peakCount(fineCount)
    );

    acqControl #(
        .nb        (nb),
        .nf        (nf),
        .countWidth(countWidth),
        .numAcq    (numAcq)
    ) i_ctrl (
        .clk        (clk),
        .res        (res),
        .start      (start),
        .hitValid   (hitValid),
        .hitReady   (hitReady),
        .hitAccept  (hitAccept),
        .clear      (clear),
        .busy       (busy),
        .done       (done),
        .irq        (irq),
        .coarseBin  (coarseBin),
        .fineBin    (fineBin),
        .coarseCount(coarseCount),
        .fineCount  (fineCount),
        .peakPos    (peakPos),
        .coarsePeak (coarsePeak),
        .finePeak   (finePeak)
    );

    axiLiteRegs #(
        .nb        (nb),
        .nf        (nf),
        .countWidth(countWidth)
    ) i_regs (
        .clk       (clk),
        .res       (res),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .start     (start),
        .busy      (busy),
        .done      (done),
        .peakPos   (peakPos),
        .coarsePeak(coarsePeak),
        .finePeak  (finePeak)
    );

endmodule

// File: source/axiLiteRegs.sv
`timescale 1ns/1ps

module axiLiteRegs #(
    parameter int nb = histPkg::defNb,
    parameter int nf = histPkg::defNf,
    parameter int countWidth = histPkg::defCountWidth
) (
    input  logic                  clk,
    input  logic                  res,
    input  logic [4:0]            awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [31:0]           wdata,
    input  logic                  wvalid,
    output logic                  wready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  logic [4:0]            araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [31:0]           rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready,
    output logic                  start,
    input  logic                  busy,
    input  logic                  done,
    input  logic [nb+nf-1:0]      peakPos,
    input  logic [countWidth-1:0] coarsePeak,
    input  logic [countWidth-1:0] finePeak
);

    import histPkg::*;

    logic        awHeld;     // address taken, waiting for data or response
    logic        wHeld;
    logic [4:0]  addrQ;
    logic [31:0] dataQ;
    logic        wrFire;
    logic [31:0] readMux;

    assign awready = !awHeld && !bvalid;
    assign wready  = !wHeld && !bvalid;
    assign arready = !rvalid;                                 // one read in flight
    assign bresp   = 2'b00;
    assign rresp   = 2'b00;
    assign wrFire  = awHeld && wHeld;

    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            addrQ <= awaddr;
        end
        if (wvalid && wready) begin
            dataQ <= wdata;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            awHeld <= 1'b0;
            wHeld  <= 1'b0;
            bvalid <= 1'b0;
            start  <= 1'b0;
        end else begin
            // only the control register has a write effect
            start <= wrFire && (addrQ == regCtrl) && dataQ[0];
            if (wrFire) begin
                awHeld <= 1'b0;
                wHeld  <= 1'b0;
                bvalid <= 1'b1;
            end else begin
                if (awvalid && awready) begin
                    awHeld <= 1'b1;
                end
                if (wvalid && wready) begin
                    wHeld <= 1'b1;
                end
                if (bvalid && bready) begin
                    bvalid <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        case (araddr)
            regStatus:      readMux = {30'd0, done, busy};
            regPeak:        readMux = 32'(peakPos);
            regCoarseCount: readMux = 32'(coarsePeak);
            regFineCount:   readMux = 32'(finePeak);
            default:        readMux = '0;             // ctrl and unmapped read as zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            rdata <= readMux;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rvalid <= 1'b0;
        end else if (arvalid && arready) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;                           // data held until rready
        end
    end

endmodule

// File: source/acqControl.sv
`timescale 1ns/1ps

module acqControl #(
    parameter int nb = histPkg::defNb,
    parameter int nf = histPkg::defNf,
    parameter int countWidth = histPkg::defCountWidth,
    parameter int numAcq = histPkg::defNumAcq
) (
    input  logic                  clk,
    input  logic                  res,
    input  logic                  start,
    input  logic                  hitValid,
    output logic                  hitReady,
    output logic                  hitAccept,
    output logic                  clear,
    output logic                  busy,
    output logic                  done,
    output logic                  irq,
    input  logic [nb-1:0]         coarseBin,
    input  logic [nf-1:0]         fineBin,
    input  logic [countWidth-1:0] coarseCount,
    input  logic [countWidth-1:0] fineCount,
    output logic [nb+nf-1:0]      peakPos,
    output logic [countWidth-1:0] coarsePeak,
    output logic [countWidth-1:0] finePeak
);

    import histPkg::*;

    localparam int cntWidth = $clog2(numAcq + 1);

    acqState               state;
    logic [cntWidth-1:0]   hitCnt;
    logic                  lastHit;
    logic [nb+nf-1:0]      heldPos;
    logic [countWidth-1:0] heldCoarse;
    logic [countWidth-1:0] heldFine;

    // a start in the same cycle wins over a pending hit
    assign hitReady  = (state == stAcquire) && !start;
    assign hitAccept = hitValid && hitReady;
    assign clear     = start;
    assign busy      = state == stAcquire;
    assign done      = state == stDone;
    assign irq       = done;                                  // level, cleared by next start
    assign lastHit   = hitAccept && (hitCnt == cntWidth'(numAcq - 1));

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state  <= stIdle;
            hitCnt <= '0;
        end else if (start) begin
            state  <= stAcquire;                              // also restarts a running one
            hitCnt <= '0;
        end else if (hitAccept) begin
            hitCnt <= hitCnt + 1'b1;
            if (lastHit) begin
                state <= stDone;
            end
        end
    end

    // results of the last finished acquisition
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            heldPos    <= '0;
            heldCoarse <= '0;
            heldFine   <= '0;
        end else if (done) begin
            heldPos    <= {coarseBin, fineBin};
            heldCoarse <= coarseCount;
            heldFine   <= fineCount;
        end
    end

    // builders are frozen in stDone, so their peaks are final from the entry edge
    assign peakPos    = done ? {coarseBin, fineBin} : heldPos;
    assign coarsePeak = done ? coarseCount : heldCoarse;
    assign finePeak   = done ? fineCount : heldFine;

endmodule

// File: source/histBuilder.sv
`timescale 1ns/1ps

module histBuilder #(
    parameter int addrWidth = histPkg::defNb,
    parameter int countWidth = histPkg::defCountWidth
) (
    input  logic                  clk,
    input  logic                  res,
    input  logic                  clear,
    input  logic                  hitAccept,
    input  logic [addrWidth-1:0]  binAddr,
    output logic [addrWidth-1:0]  peakBin,
    output logic [countWidth-1:0] peakCount
);

    localparam int numBins = 2 ** addrWidth;

    logic [countWidth-1:0] binMem [numBins];
    logic [numBins-1:0]    binValid;     // lazy clear flags
    logic [countWidth-1:0] newCount;

    // stale bins restart at one
    assign newCount = binValid[binAddr] ? binMem[binAddr] + 1'b1 : countWidth'(1);

    always_ff @(posedge clk) begin
        if (hitAccept) begin
            binMem[binAddr] <= newCount;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            binValid  <= '0;
            peakBin   <= '0;
            peakCount <= '0;
        end else if (clear) begin
            binValid  <= '0;             // whole array invalid in one cycle
            peakBin   <= '0;
            peakCount <= '0;
        end else if (hitAccept) begin
            binValid[binAddr] <= 1'b1;
            // strictly greater, so on a tie the earlier bin keeps the peak
            if (newCount > peakCount) begin
                peakBin   <= binAddr;
                peakCount <= newCount;
            end
        end
    end

endmodule

// File: source/histPkg.sv
package histPkg;

    // default widths, overridden from the top level
    parameter int defNb = 6;            // coarse bin address bits
    parameter int defNf = 4;            // fine bin address bits
    parameter int defCountWidth = 21;
    parameter int defNumAcq = 64;       // hits per acquisition

    typedef enum logic [1:0] {
        stIdle,
        stAcquire,
        stDone
    } acqState;

    // AXI4-Lite byte offsets
    typedef enum logic [4:0] {
        regCtrl        = 5'h00,
        regStatus      = 5'h04,
        regPeak        = 5'h08,
        regCoarseCount = 5'h0C,
        regFineCount   = 5'h10
    } regAddr;

endpackage
